// ==== common/exu_pkg.sv ====
package exu_pkg;

  // datapath and register file geometry
  localparam int XLEN      = 64;
  localparam int REG_IDX_W = 5;

  // request class, picks the unit that owns the write-back value
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_BJP = 2'd1,
    UNIT_LS  = 2'd2,
    UNIT_MDU = 2'd3
  } exu_unit_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_LUI  = 4'd10
  } alu_op_e;

  typedef enum logic [2:0] {
    BJP_JAL  = 3'd0,
    BJP_JALR = 3'd1,
    BJP_BEQ  = 3'd2,
    BJP_BNE  = 3'd3,
    BJP_BLT  = 3'd4,
    BJP_BGE  = 3'd5,
    BJP_BLTU = 3'd6,
    BJP_BGEU = 3'd7
  } bjp_op_e;

  typedef enum logic [1:0] {
    MDU_MUL    = 2'd0,
    MDU_MULH   = 2'd1,
    MDU_MULHSU = 2'd2,
    MDU_MULHU  = 2'd3
  } mdu_op_e;

  typedef enum logic [1:0] {
    LS_BYTE  = 2'd0,
    LS_HALF  = 2'd1,
    LS_WORD  = 2'd2,
    LS_DWORD = 2'd3
  } ls_size_e;

  // memory control handed to the next stage
  typedef struct packed {
    logic     load;
    logic     store;
    logic     usign;
    ls_size_e size;
  } ls_info_t;

  typedef struct packed {
    logic                 valid;
    exu_unit_e            unit;
    alu_op_e              alu_op;
    bjp_op_e              bjp_op;
    mdu_op_e              mdu_op;
    logic                 wop;
    logic                 ls_load;
    logic                 ls_store;
    logic                 ls_unsigned;
    ls_size_e             ls_size;
    logic                 ebreak;
    logic                 illegal;
    logic                 rd_we;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [XLEN-1:0]      op1;
    logic [XLEN-1:0]      op2;
    logic [XLEN-1:0]      jp_base;
    // jump offset, or rs2 data for a store
    logic [XLEN-1:0]      jp_off_sdata;
  } exu_req_t;

  typedef struct packed {
    logic                 valid;
    logic                 rd_we;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [XLEN-1:0]      result;
    ls_info_t             ls_info;
    logic [XLEN-1:0]      store_data;
    logic                 jump_taken;
    logic [XLEN-1:0]      jump_addr;
    logic                 halt_ebreak;
    logic                 halt_illegal;
  } exu_res_t;

  // results of op1 - op2
  typedef struct packed {
    logic zero;
    logic lt;
    logic ltu;
  } cmp_flags_t;

  // word ops keep the low half and sign-extend bit 31
  function automatic logic [XLEN-1:0] sext_w(input logic [31:0] val);
    return {{(XLEN-32){val[31]}}, val};
  endfunction

endpackage

// ==== exu/exu_alu.sv ====
`timescale 1ns/10ps

module exu_alu
  import exu_pkg::*;
(
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  input  alu_op_e         alu_op_i,
  input  logic            alu_en_i,
  input  logic            force_add_i,
  input  logic            wop_i,
  output logic [XLEN-1:0] result_o,
  output cmp_flags_t      flags_o
);

  logic [XLEN-1:0] sum;
  logic [XLEN:0]   diff_ext;
  logic [XLEN-1:0] diff;
  logic [5:0]      shamt;
  logic [4:0]      shamt_w;
  logic [31:0]     sllw;
  logic [31:0]     srlw;
  logic [31:0]     sraw;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;
  logic [XLEN-1:0] op_res;

  // add path, also used for addresses and link values
  assign sum = op1_i + op2_i;

  // subtract path as op1 + ~op2 + 1, compare flags always come from here
  assign diff_ext = {1'b0, op1_i} + {1'b0, ~op2_i} + {{XLEN{1'b0}}, 1'b1};
  assign diff     = diff_ext[XLEN-1:0];

  assign flags_o.zero = (diff == '0);
  // no carry out means a borrow
  assign flags_o.ltu  = ~diff_ext[XLEN];
  assign flags_o.lt   = (op1_i[XLEN-1] & ~op2_i[XLEN-1]) |
                        (~(op1_i[XLEN-1] ^ op2_i[XLEN-1]) & diff[XLEN-1]);

  // word shifts only look at 5 bits of the amount
  assign shamt   = op2_i[5:0];
  assign shamt_w = op2_i[4:0];

  assign sllw = op1_i[31:0] << shamt_w;
  assign srlw = op1_i[31:0] >> shamt_w;
  assign sraw = $signed(op1_i[31:0]) >>> shamt_w;

  always_comb begin
    if (wop_i) begin
      sll_res = sext_w(sllw);
      srl_res = sext_w(srlw);
      sra_res = sext_w(sraw);
    end else begin
      sll_res = op1_i << shamt;
      srl_res = op1_i >> shamt;
      sra_res = $signed(op1_i) >>> shamt;
    end
  end

  always_comb begin
    op_res = '0;
    case (alu_op_i)
      ALU_ADD: begin
        op_res = wop_i ? sext_w(sum[31:0]) : sum;
      end
      ALU_SUB: begin
        op_res = wop_i ? sext_w(diff[31:0]) : diff;
      end
      ALU_SLL: begin
        op_res = sll_res;
      end
      ALU_SRL: begin
        op_res = srl_res;
      end
      ALU_SRA: begin
        op_res = sra_res;
      end
      ALU_SLT: begin
        op_res = {{(XLEN-1){1'b0}}, flags_o.lt};
      end
      ALU_SLTU: begin
        op_res = {{(XLEN-1){1'b0}}, flags_o.ltu};
      end
      ALU_XOR: begin
        op_res = op1_i ^ op2_i;
      end
      ALU_OR: begin
        op_res = op1_i | op2_i;
      end
      ALU_AND: begin
        op_res = op1_i & op2_i;
      end
      // immediate already shifted by decode
      ALU_LUI: begin
        op_res = op2_i;
      end
      default: begin
        op_res = '0;
      end
    endcase
  end

  // forced add wins over the decoded op
  always_comb begin
    if (force_add_i) begin
      result_o = sum;
    end else if (alu_en_i) begin
      result_o = op_res;
    end else begin
      result_o = '0;
    end
  end

endmodule

// ==== exu/exu_bjp.sv ====
`timescale 1ns/10ps

module exu_bjp
  import exu_pkg::*;
(
  input  logic            bjp_en_i,
  input  bjp_op_e         bjp_op_i,
  input  cmp_flags_t      flags_i,
  input  logic [XLEN-1:0] jp_base_i,
  input  logic [XLEN-1:0] jp_off_i,
  output logic            jump_taken_o,
  output logic [XLEN-1:0] jump_addr_o
);

  logic            cond;
  logic [XLEN-1:0] target;

  // branch condition from op1 - op2
  always_comb begin
    cond = 1'b0;
    case (bjp_op_i)
      BJP_JAL, BJP_JALR: begin
        cond = 1'b1;
      end
      BJP_BEQ: begin
        cond = flags_i.zero;
      end
      BJP_BNE: begin
        cond = ~flags_i.zero;
      end
      BJP_BLT: begin
        cond = flags_i.lt;
      end
      BJP_BGE: begin
        cond = ~flags_i.lt;
      end
      BJP_BLTU: begin
        cond = flags_i.ltu;
      end
      BJP_BGEU: begin
        cond = ~flags_i.ltu;
      end
      default: begin
        cond = 1'b0;
      end
    endcase
  end

  assign target = jp_base_i + jp_off_i;

  assign jump_taken_o = bjp_en_i & cond;

  // jalr drops bit 0 of the target
  assign jump_addr_o = (bjp_op_i == BJP_JALR) ? {target[XLEN-1:1], 1'b0} : target;

endmodule

// ==== exu/exu_mdu.sv ====
`timescale 1ns/10ps

module exu_mdu
  import exu_pkg::*;
(
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  input  mdu_op_e         mdu_op_i,
  input  logic            wop_i,
  output logic [XLEN-1:0] result_o
);

  logic              op1_signed;
  logic              op2_signed;
  logic [XLEN:0]     op1_ext;
  logic [XLEN:0]     op2_ext;
  logic [2*XLEN-1:0] prod;

  // signedness per op, mulhsu keeps op2 unsigned
  assign op1_signed = (mdu_op_i == MDU_MULH) || (mdu_op_i == MDU_MULHSU);
  assign op2_signed = (mdu_op_i == MDU_MULH);

  // one extra bit turns every case into a signed multiply
  assign op1_ext = {op1_signed & op1_i[XLEN-1], op1_i};
  assign op2_ext = {op2_signed & op2_i[XLEN-1], op2_i};

  assign prod = $signed(op1_ext) * $signed(op2_ext);

  always_comb begin
    if (mdu_op_i == MDU_MUL) begin
      result_o = wop_i ? sext_w(prod[31:0]) : prod[XLEN-1:0];
    end else begin
      result_o = prod[2*XLEN-1:XLEN];
    end
  end

endmodule

// ==== exu/exu_core.sv ====
`timescale 1ns/10ps

module exu_core
  import exu_pkg::*;
(
  input  exu_req_t req_i,
  output exu_res_t res_o
);

  logic            alu_req;
  logic            bjp_req;
  logic            ls_req;
  logic            mdu_req;
  logic            force_add;
  logic            is_store;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] mdu_res;
  cmp_flags_t      flags;
  logic            jump_taken;
  logic [XLEN-1:0] jump_addr;
  ls_info_t        ls_info;

  // request class
  assign alu_req = (req_i.unit == UNIT_ALU);
  assign bjp_req = (req_i.unit == UNIT_BJP);
  assign ls_req  = (req_i.unit == UNIT_LS);
  assign mdu_req = (req_i.unit == UNIT_MDU);

  // address for ls, link value for bjp
  assign force_add = ls_req | bjp_req;

  exu_alu u_alu (
    .op1_i       (req_i.op1),
    .op2_i       (req_i.op2),
    .alu_op_i    (req_i.alu_op),
    .alu_en_i    (alu_req),
    .force_add_i (force_add),
    .wop_i       (alu_req & req_i.wop),
    .result_o    (alu_res),
    .flags_o     (flags)
  );

  exu_bjp u_bjp (
    .bjp_en_i     (req_i.valid & bjp_req),
    .bjp_op_i     (req_i.bjp_op),
    .flags_i      (flags),
    .jp_base_i    (req_i.jp_base),
    .jp_off_i     (req_i.jp_off_sdata),
    .jump_taken_o (jump_taken),
    .jump_addr_o  (jump_addr)
  );

  exu_mdu u_mdu (
    .op1_i    (req_i.op1),
    .op2_i    (req_i.op2),
    .mdu_op_i (req_i.mdu_op),
    .wop_i    (mdu_req & req_i.wop),
    .result_o (mdu_res)
  );

  // memory control only for ls requests
  assign is_store      = ls_req & req_i.ls_store;
  assign ls_info.load  = ls_req & req_i.ls_load;
  assign ls_info.store = is_store;
  assign ls_info.usign = ls_req & req_i.ls_unsigned;
  assign ls_info.size  = ls_req ? req_i.ls_size : LS_BYTE;

  always_comb begin
    res_o            = '0;
    res_o.valid      = req_i.valid;
    res_o.rd_we      = req_i.rd_we;
    res_o.rd_idx     = req_i.rd_idx;
    // alu covers alu, ls and bjp
    res_o.result     = mdu_req ? mdu_res : alu_res;
    res_o.ls_info    = ls_info;
    res_o.store_data = is_store ? req_i.jp_off_sdata : '0;
    res_o.jump_taken = jump_taken;
    res_o.jump_addr  = jump_addr;
    res_o.halt_ebreak  = req_i.valid & req_i.ebreak;
    res_o.halt_illegal = req_i.valid & req_i.illegal;
  end

endmodule

// ==== src/ex_mem_reg.sv ====
`timescale 1ns/10ps

module ex_mem_reg
  import exu_pkg::*;
(
  input  logic     clk,
  input  logic     reset_i,
  input  exu_res_t d_i,
  output exu_res_t q_o
);

  // data fields follow d_i every edge, even in reset
  always_ff @(posedge clk) begin
    q_o <= d_i;
    if (reset_i) begin
      q_o.valid        <= 1'b0;
      q_o.jump_taken   <= 1'b0;
      q_o.halt_ebreak  <= 1'b0;
      q_o.halt_illegal <= 1'b0;
    end
  end

endmodule

// ==== src/exu_stage.sv ====
`timescale 1ns/10ps

module exu_stage
  import exu_pkg::*;
(
  input  logic     clk,
  input  logic     reset_i,
  input  exu_req_t req_i,
  output exu_res_t res_o
);

  // combinational execute result
  exu_res_t core_res;

  exu_core u_exu_core (
    .req_i (req_i),
    .res_o (core_res)
  );

  // one cycle to the memory stage
  ex_mem_reg u_ex_mem_reg (
    .clk     (clk),
    .reset_i (reset_i),
    .d_i     (core_res),
    .q_o     (res_o)
  );

endmodule

// ==== verification/exu_model.svh ====
// expected value of one ALU op, word forms sign-extend bit 31
function automatic logic [XLEN-1:0] alu_value(input alu_op_e op, input logic w,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
  logic [5:0]      sh;
  logic [XLEN-1:0] x;
  logic [XLEN-1:0] v;
  sh = w ? {1'b0, b[4:0]} : b[5:0];
  x  = w ? {{32{a[31]}}, a[31:0]} : a;
  case (op)
    ALU_ADD:  v = a + b;
    ALU_SUB:  v = a - b;
    ALU_SLL:  v = x << sh;
    ALU_SRL:  v = (w ? {32'b0, a[31:0]} : a) >> sh;
    ALU_SRA:  v = $signed(x) >>> sh;
    ALU_SLT:  v = {63'b0, $signed(a) < $signed(b)};
    ALU_SLTU: v = {63'b0, a < b};
    ALU_XOR:  v = a ^ b;
    ALU_OR:   v = a | b;
    ALU_AND:  v = a & b;
    ALU_LUI:  v = b;
    default:  v = '0;
  endcase
  if (w && (op == ALU_ADD || op == ALU_SUB || op == ALU_SLL ||
            op == ALU_SRL || op == ALU_SRA)) begin
    v = {{32{v[31]}}, v[31:0]};
  end
  return v;
endfunction

// full result the stage should register for one request
function automatic exu_res_t predict_result(input exu_req_t r);
  exu_res_t          e;
  logic [2*XLEN-1:0] pa;
  logic [2*XLEN-1:0] pb;
  logic [2*XLEN-1:0] prod;
  logic              taken;
  e        = '0;
  taken    = 1'b0;
  e.valid  = r.valid;
  e.rd_we  = r.rd_we;
  e.rd_idx = r.rd_idx;
  // address for ls, link value for bjp
  e.result = r.op1 + r.op2;
  case (r.unit)
    UNIT_ALU: e.result = alu_value(r.alu_op, r.wop, r.op1, r.op2);
    UNIT_MDU: begin
      // extend both to 128 bits, the wrapped product is exact
      pa = {{XLEN{1'b0}}, r.op1};
      pb = {{XLEN{1'b0}}, r.op2};
      if (r.mdu_op == MDU_MULH || r.mdu_op == MDU_MULHSU) begin
        pa[2*XLEN-1:XLEN] = {XLEN{r.op1[XLEN-1]}};
      end
      if (r.mdu_op == MDU_MULH) begin
        pb[2*XLEN-1:XLEN] = {XLEN{r.op2[XLEN-1]}};
      end
      prod = pa * pb;
      if (r.mdu_op != MDU_MUL) begin
        e.result = prod[2*XLEN-1:XLEN];
      end else begin
        e.result = r.wop ? {{32{prod[31]}}, prod[31:0]} : prod[XLEN-1:0];
      end
    end
    UNIT_LS: begin
      e.ls_info.load  = r.ls_load;
      e.ls_info.store = r.ls_store;
      e.ls_info.usign = r.ls_unsigned;
      e.ls_info.size  = r.ls_size;
      e.store_data    = r.ls_store ? r.jp_off_sdata : '0;
    end
    default: begin
      case (r.bjp_op)
        BJP_BEQ:  taken = (r.op1 == r.op2);
        BJP_BNE:  taken = (r.op1 != r.op2);
        BJP_BLT:  taken = ($signed(r.op1) < $signed(r.op2));
        BJP_BGE:  taken = ($signed(r.op1) >= $signed(r.op2));
        BJP_BLTU: taken = (r.op1 < r.op2);
        BJP_BGEU: taken = (r.op1 >= r.op2);
        default:  taken = 1'b1;
      endcase
    end
  endcase
  e.jump_taken = r.valid & taken;
  e.jump_addr  = r.jp_base + r.jp_off_sdata;
  if (r.bjp_op == BJP_JALR) begin
    e.jump_addr[0] = 1'b0;
  end
  e.halt_ebreak  = r.valid & r.ebreak;
  e.halt_illegal = r.valid & r.illegal;
  return e;
endfunction

// ==== verification/tb_exu_stage.sv ====
`timescale 1ns/10ps

module tb_exu_stage;
  import exu_pkg::*;

  // about 170 cycles of tests plus margin
  localparam int MAX_CYCLES = 400;

  logic        clk;
  logic        reset_i;
  exu_req_t    req;
  exu_res_t    res;
  exu_req_t    pend_req;
  exu_res_t    exp_res;
  logic        pending;
  int          cycles = 0;
  logic [31:0] lfsr_state = 32'hf55d_9dbc;

  `include "exu_model.svh"

  exu_stage UUT (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (req),
    .res_o   (res)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      report_fail("timeout, the tests did not finish within the cycle limit");
    end
  end

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  // galois lfsr, one step per bit
  function automatic logic lfsr_bit();
    logic b;
    b          = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  function automatic logic [XLEN-1:0] rand_bits(input int n);
    logic [XLEN-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[XLEN-2:0], lfsr_bit()};
    end
    return v;
  endfunction

  task automatic match_field(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    assert (got === exp) else begin
      report_fail($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // data fields only matter for a valid request
  task automatic compare_result();
    match_field("res_o.valid", res.valid, exp_res.valid);
    match_field("res_o.jump_taken", res.jump_taken, exp_res.jump_taken);
    match_field("res_o.halt_ebreak", res.halt_ebreak, exp_res.halt_ebreak);
    match_field("res_o.halt_illegal", res.halt_illegal, exp_res.halt_illegal);
    if (exp_res.valid) begin
      match_field("res_o.rd_we", res.rd_we, exp_res.rd_we);
      match_field("res_o.rd_idx", res.rd_idx, exp_res.rd_idx);
      match_field("res_o.result", res.result, exp_res.result);
      match_field("res_o.ls_info", res.ls_info, exp_res.ls_info);
      match_field("res_o.store_data", res.store_data, exp_res.store_data);
      if (pend_req.unit == UNIT_BJP) begin
        match_field("res_o.jump_addr", res.jump_addr, exp_res.jump_addr);
      end
    end
  endtask

  // drive after the edge, check the previous request one cycle later
  task automatic send_req(input exu_req_t r);
    @(posedge clk);
    #2;
    if (pending) begin
      compare_result();
    end
    req      = r;
    pend_req = r;
    exp_res  = predict_result(r);
    pending  = 1'b1;
  endtask

  task automatic flush_pipe();
    @(posedge clk);
    #2;
    if (pending) begin
      compare_result();
    end
    req     = '0;
    pending = 1'b0;
  endtask

  function automatic exu_req_t build_req(input exu_unit_e unit, input logic [XLEN-1:0] a,
                                         input logic [XLEN-1:0] b);
    exu_req_t r;
    r        = '0;
    r.valid  = 1'b1;
    r.unit   = unit;
    r.rd_we  = 1'b1;
    r.rd_idx = rand_bits(REG_IDX_W);
    r.op1    = a;
    r.op2    = b;
    return r;
  endfunction

  task automatic alu_ops();
    exu_req_t   r;
    logic [5:0] amounts [4];
    amounts = '{6'd0, 6'd31, 6'd32, 6'd63};
    for (int op = 0; op <= 10; op++) begin
      for (int n = 0; n < 3; n++) begin
        r        = build_req(UNIT_ALU, rand_bits(64), rand_bits(64));
        r.alu_op = alu_op_e'(op);
        send_req(r);
      end
    end
    // full and word form of add, sub and the shifts
    for (int op = 0; op <= 4; op++) begin
      for (int n = 0; n < 8; n++) begin
        r        = build_req(UNIT_ALU, rand_bits(64), rand_bits(64));
        r.alu_op = alu_op_e'(op);
        r.wop    = n[0];
        if (op >= 2) begin
          r.op2[5:0] = amounts[n >> 1];
        end
        send_req(r);
      end
    end
    // one operand negative, the other positive
    for (int n = 0; n < 4; n++) begin
      r = build_req(UNIT_ALU, rand_bits(63) | {n[1], 63'b0}, rand_bits(63) | {~n[1], 63'b0});
      r.alu_op = n[0] ? ALU_SLTU : ALU_SLT;
      send_req(r);
    end
    flush_pipe();
  endtask

  task automatic branch_jumps();
    exu_req_t        r;
    logic [XLEN-1:0] x;
    for (int op = 0; op < 8; op++) begin
      for (int n = 0; n < 4; n++) begin
        x = rand_bits(64);
        case (n)
          0: r = build_req(UNIT_BJP, x, x);
          1: r = build_req(UNIT_BJP, x, x + 1);
          2: r = build_req(UNIT_BJP, x + 1, x);
          default: r = build_req(UNIT_BJP, '1, 64'd1);
        endcase
        r.bjp_op       = bjp_op_e'(op);
        r.jp_base      = rand_bits(64);
        // odd offset gives jalr a bit 0 to clear
        r.jp_off_sdata = rand_bits(64) | 64'd1;
        send_req(r);
      end
    end
    flush_pipe();
  endtask

  task automatic load_stores();
    exu_req_t r;
    for (int sz = 0; sz < 4; sz++) begin
      for (int n = 0; n < 4; n++) begin
        r              = build_req(UNIT_LS, rand_bits(64), rand_bits(12));
        r.ls_size      = ls_size_e'(sz);
        r.ls_store     = n[0];
        r.ls_load      = ~n[0];
        r.ls_unsigned  = n[1];
        r.rd_we        = ~n[0];
        r.jp_off_sdata = rand_bits(64);
        send_req(r);
      end
    end
    flush_pipe();
  endtask

  task automatic multiplies();
    exu_req_t r;
    for (int op = 0; op < 4; op++) begin
      for (int n = 0; n < 7; n++) begin
        case (n)
          0: r = build_req(UNIT_MDU, {1'b1, 63'b0}, '1);
          1: r = build_req(UNIT_MDU, '1, '1);
          2: r = build_req(UNIT_MDU, rand_bits(64), '1);
          3: r = build_req(UNIT_MDU, '1, rand_bits(64));
          default: r = build_req(UNIT_MDU, rand_bits(64), rand_bits(64));
        endcase
        r.mdu_op = mdu_op_e'(op);
        r.wop    = (op == 0) ? n[0] : 1'b0;
        send_req(r);
      end
    end
    flush_pipe();
  endtask

  task automatic back_to_back();
    exu_req_t r;
    r = build_req(UNIT_ALU, rand_bits(64), rand_bits(64));
    send_req(r);
    r.ebreak = 1'b1;
    send_req(r);
    r.ebreak  = 1'b0;
    r.illegal = 1'b1;
    send_req(r);
    // dropped request must not redirect or halt
    r         = build_req(UNIT_BJP, 64'd7, 64'd7);
    r.valid   = 1'b0;
    r.bjp_op  = BJP_JAL;
    r.ebreak  = 1'b1;
    r.illegal = 1'b1;
    send_req(r);
    r.bjp_op = BJP_BEQ;
    send_req(r);
    send_req(build_req(UNIT_MDU, rand_bits(64), rand_bits(64)));
    flush_pipe();
  endtask

  initial begin
    reset_i     = 1'b1;
    pending     = 1'b0;
    req         = '0;
    // live request during reset, nothing may leak to res_o
    req.valid   = 1'b1;
    req.unit    = UNIT_BJP;
    req.ebreak  = 1'b1;
    req.illegal = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    match_field("res_o.valid", res.valid, 1'b0);
    match_field("res_o.jump_taken", res.jump_taken, 1'b0);
    match_field("res_o.halt_ebreak", res.halt_ebreak, 1'b0);
    match_field("res_o.halt_illegal", res.halt_illegal, 1'b0);
    reset_i = 1'b0;
    req     = '0;
    alu_ops();
    branch_jumps();
    load_stores();
    multiplies();
    back_to_back();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+verification
common/exu_pkg.sv
exu/exu_alu.sv
exu/exu_bjp.sv
exu/exu_mdu.sv
exu/exu_core.sv
src/ex_mem_reg.sv
src/exu_stage.sv
verification/tb_exu_stage.sv

// ==== Bender.yml ====
package:
  name: exu_stage

sources:
  - files:
      - common/exu_pkg.sv
      - exu/exu_alu.sv
      - exu/exu_bjp.sv
      - exu/exu_mdu.sv
      - exu/exu_core.sv
      - src/ex_mem_reg.sv
      - src/exu_stage.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_exu_stage.sv
